// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run accel_tb"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module accel_tb -f list.f
	@out="$$(./obj_dir/Vaccel_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== dv/accel_stimulus.txt ====
// pair line:     1_<a>_<b>_<last>_000000
// expected line: 2_<core 0>_<core 1>_<core 2>_<core 3>
// every field 24 bit hex, pair k lands in core k mod 4

// job 0, two pairs per core
1_000012_000034_000000_000000
1_000005_000007_000000_000000
1_0000ff_0000ff_000000_000000
1_000080_000002_000000_000000
1_000010_000010_000000_000000
1_000003_0000a0_000000_000000
1_000001_000001_000000_000000
1_000040_000040_000001_000000
2_0004a8_000203_00fe02_001100

// job 1, short job, cores 2 and 3 stay at zero
1_00000a_00000b_000000_000000
1_0000c8_000003_000001_000000
2_00006e_000258_000000_000000

// job 2, wraps back to core 0 once
1_000002_000003_000000_000000
1_000011_000011_000000_000000
1_00007f_000081_000000_000000
1_000000_0000ff_000000_000000
1_000064_000064_000001_000000
2_002716_000121_003fff_000000

// job 3, largest operands
1_0000ff_0000ff_000000_000000
1_0000ff_0000ff_000000_000000
1_0000ff_0000ff_000000_000000
1_0000ff_0000ff_000001_000000
2_00fe01_00fe01_00fe01_00fe01

// job 4, single pair right after the full job
1_000009_000009_000001_000000
2_000051_000000_000000_000000

// job 5, three rounds
1_000001_000002_000000_000000
1_000003_000004_000000_000000
1_000005_000006_000000_000000
1_000007_000008_000000_000000
1_000009_00000a_000000_000000
1_00000b_00000c_000000_000000
1_00000d_00000e_000000_000000
1_00000f_000010_000000_000000
1_0000f0_0000f0_000000_000000
1_0000aa_000055_000000_000000
1_000033_0000cc_000000_000000
1_0000fe_000001_000001_000000
2_00e15c_003902_002978_000226

// ==== dv/accel_tb.sv ====
module accel_tb
    import accel_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // records, limits, DUT signals
    // ==================================================

    // tag nibble over four 24 bit fields
    localparam int         STIM_DEPTH   = 64;
    localparam int         WORD_TIMEOUT = 100;
    localparam logic [3:0] TAG_PAIR     = 4'd1;
    localparam logic [3:0] TAG_EXPECT   = 4'd2;

    logic     clk       = 1'b0;
    logic     rst       = 1'b1;
    logic     in_v      = 1'b0;
    operand_t in_a      = '0;
    operand_t in_b      = '0;
    logic     in_last   = 1'b0;
    logic     dst_ready = 1'b0;
    logic     dst_valid;
    acc_t     dst_data;
    logic     dst_last;

    logic [99:0] stim_mem [STIM_DEPTH];
    logic [16:0] ready_lfsr = 17'd96444;
    logic [16:0] gap_lfsr   = 17'd96444;

    // words seen by the monitor, oldest first
    acc_t data_q [$];
    logic last_q [$];
    // word parked under a low dst_ready
    logic stall_seen = 1'b0;
    acc_t held_data;
    logic held_last;

    int   value_errors    = 0;
    int   protocol_errors = 0;
    int   timeouts        = 0;
    logic timed_out       = 1'b0;

    accel_top i_accel_top (
        .clk       (clk),
        .rst       (rst),
        .in_v      (in_v),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_last   (in_last),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_data  (dst_data),
        .dst_last  (dst_last)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // fibonacci, taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    // one fresh bit per cycle for back-pressure
    always @(posedge clk) begin
        ready_lfsr = lfsr_next(ready_lfsr);
        dst_ready <= ready_lfsr[0];
    end

    // idle cycles before a pair, 0 to 3
    task automatic pick_gap(output int gap);
        logic [1:0] bits;
        gap_lfsr = lfsr_next(gap_lfsr);
        bits[1]  = gap_lfsr[0];
        gap_lfsr = lfsr_next(gap_lfsr);
        bits[0]  = gap_lfsr[0];
        gap      = int'(bits);
    endtask

    task automatic drive_pair(input operand_t a, input operand_t b, input logic last);
        int gap;
        pick_gap(gap);
        repeat (gap) begin
            @(posedge clk);
            in_v    <= 1'b0;
            in_last <= 1'b0;
        end
        @(posedge clk);
        in_v    <= 1'b1;
        in_a    <= a;
        in_b    <= b;
        in_last <= last;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (dst_valid !== 1'b0 || dst_last !== 1'b0) begin
                $display("Error at %0d ns: dst_valid or dst_last high with no input", $time);
                protocol_errors++;
            end
        end
    endtask

    // ==================================================
    // result checks per job
    // ==================================================

    task automatic check_job(input logic [99:0] rec_word, input int job);
        acc_t expected;
        acc_t got_data;
        logic got_last;
        int   waited;
        int   k;
        // drop the strobe of the final pair
        @(posedge clk);
        in_v    <= 1'b0;
        in_last <= 1'b0;
        for (k = 0; k < CORE_NUM; k++) begin
            // core 0 is the leftmost field
            expected = rec_word[95 - k*ACC_W -: ACC_W];
            waited   = 0;
            while (data_q.size() == 0 && waited < WORD_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (data_q.size() == 0) begin
                $display("no result word %0d of job %0d arrived in time", k, job);
                timeouts++;
                timed_out = 1'b1;
                return;
            end
            got_data = data_q.pop_front();
            got_last = last_q.pop_front();
            if (got_data !== expected) begin
                $display("Error at %0d ns: job %0d word %0d is %h, expected %h",
                         $time, job, k, got_data, expected);
                value_errors++;
            end
            if (got_last !== (k == CORE_NUM - 1)) begin
                $display("Error at %0d ns: job %0d word %0d has dst_last %b",
                         $time, job, k, got_last);
                protocol_errors++;
            end
        end
    endtask

    // ==================================================
    // output monitor
    // ==================================================

    always @(posedge clk) begin
        if (!rst) begin
            // parked word must come back unchanged
            if (stall_seen && (dst_valid !== 1'b1 || dst_data !== held_data
                    || dst_last !== held_last)) begin
                $display("Error at %0d ns: stalled word changed before transfer", $time);
                protocol_errors++;
            end
            if (dst_valid && dst_ready) begin
                data_q.push_back(dst_data);
                last_q.push_back(dst_last);
            end
            stall_seen = dst_valid && !dst_ready;
            held_data  = dst_data;
            held_last  = dst_last;
        end
    end

    initial begin
        logic [99:0] rec_word;
        int          rec;
        int          jobs;
        foreach (stim_mem[i]) begin
            stim_mem[i] = '0;
        end
        // zero tag past the last line ends the list
        $readmemh("dv/accel_stimulus.txt", stim_mem);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_idle(20);
        rec  = 0;
        jobs = 0;
        while (!timed_out && rec < STIM_DEPTH && stim_mem[rec][99:96] != 4'd0) begin
            rec_word = stim_mem[rec];
            if (rec_word[99:96] == TAG_PAIR) begin
                drive_pair(rec_word[79:72], rec_word[55:48], rec_word[24]);
            end
            else if (rec_word[99:96] == TAG_EXPECT) begin
                check_job(rec_word, jobs);
                jobs++;
            end
            else begin
                $display("stimulus record %0d has an unknown tag", rec);
                protocol_errors++;
            end
            rec++;
        end
        if (jobs == 0) begin
            $display("stimulus file held no complete job");
            protocol_errors++;
        end
        // extra words would mean a job streamed too many
        repeat (20) @(negedge clk);
        if (data_q.size() != 0) begin
            $display("%0d result words arrived that no job expected", data_q.size());
            protocol_errors++;
        end
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/accel_pkg.sv
source/core_dispatch.sv
source/mac_core.sv
source/agu.sv
source/stream_ctrl.sv
source/accel_top.sv
dv/accel_tb.sv

// ==== source/accel_pkg.sv ====
package accel_pkg;

    // ==================================================
    // array size and datapath widths
    // ==================================================

    // number of mac cores in the array
    localparam int CORE_NUM   = 4;
    localparam int CORE_IDX_W = 2;

    // unsigned operands, full width product
    localparam int OPERAND_W  = 8;
    localparam int PRODUCT_W  = 16;
    // running sum wraps modulo 2^24
    localparam int ACC_W      = 24;

    typedef logic [OPERAND_W-1:0]      operand_t;
    typedef logic [PRODUCT_W-1:0]      product_t;
    typedef logic [ACC_W-1:0]          acc_t;
    typedef logic [CORE_IDX_W-1:0]     core_idx_t;
    typedef logic [CORE_NUM-1:0]       core_mask_t;
    // core 0 sits in the low bits
    typedef logic [CORE_NUM*ACC_W-1:0] acc_bus_t;

    // output sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_settle,
        st_stream,
        st_drain
    } stream_state_t;

endpackage

// ==== source/accel_top.sv ====
`default_nettype none

module accel_top
    import accel_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // host pairs
    input  logic     in_v,
    input  operand_t in_a,
    input  operand_t in_b,
    input  logic     in_last,

    // result stream
    input  logic     dst_ready,
    output logic     dst_valid,
    output acc_t     dst_data,
    output logic     dst_last
);

    // dispatch to cores
    operand_t   pair_a;
    operand_t   pair_b;
    core_mask_t pair_sel;
    logic       job_last;

    // cores to sequencer
    acc_bus_t   acc_bus;
    logic       acc_clr;

    core_dispatch i_core_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_v     (in_v),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_last  (in_last),
        .pair_a   (pair_a),
        .pair_b   (pair_b),
        .pair_sel (pair_sel),
        .job_last (job_last)
    );

    // ==================================================
    // core array
    // ==================================================

    for (genvar g = 0; g < CORE_NUM; g++) begin : g_core
        mac_core i_mac_core (
            .clk     (clk),
            .rst     (rst),
            .pair_a  (pair_a),
            .pair_b  (pair_b),
            .take    (pair_sel[g]),
            .acc_clr (acc_clr),
            .acc     (acc_bus[g*ACC_W +: ACC_W])
        );
    end

    stream_ctrl i_stream_ctrl (
        .clk       (clk),
        .rst       (rst),
        .job_last  (job_last),
        .acc_bus   (acc_bus),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_data  (dst_data),
        .dst_last  (dst_last),
        .acc_clr   (acc_clr)
    );

endmodule

`default_nettype wire

// ==== source/agu.sv ====
`default_nettype none

module agu
    import accel_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // start with en loads ini, en alone counts
    input  logic      start,
    input  logic      en,
    input  core_idx_t ini,
    input  core_idx_t fin,

    output core_idx_t data,
    output logic      last
);

    // ==================================================
    // index counter
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= ini;
        end
        else if (en) begin
            if (start) begin
                data <= ini;
            end
            else begin
                // wraps past fin on its own
                data <= data + 1'b1;
            end
        end
    end

    // final index flag
    assign last = (data == fin);

endmodule

`default_nettype wire

// ==== source/core_dispatch.sv ====
`default_nettype none

module core_dispatch
    import accel_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // host side, strobe only
    input  logic       in_v,
    input  operand_t   in_a,
    input  operand_t   in_b,
    input  logic       in_last,

    // shared pair bus and per-core select
    output operand_t   pair_a,
    output operand_t   pair_b,
    output core_mask_t pair_sel,
    output logic       job_last
);

    // next core to receive a pair
    core_idx_t rr_ptr;

    // ==================================================
    // round-robin pointer
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end
        else if (in_v) begin
            // every job starts over at core 0
            if (in_last) begin
                rr_ptr <= '0;
            end
            else if (rr_ptr == core_idx_t'(CORE_NUM - 1)) begin
                rr_ptr <= '0;
            end
            else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    // pair payload, shared by all cores
    always_ff @(posedge clk) begin
        if (in_v) begin
            pair_a <= in_a;
            pair_b <= in_b;
        end
    end

    // one-hot select and job end, aligned with the payload
    always_ff @(posedge clk) begin
        if (rst) begin
            pair_sel <= '0;
            job_last <= 1'b0;
        end
        else begin
            pair_sel <= in_v ? (core_mask_t'(1) << rr_ptr) : '0;
            job_last <= in_v & in_last;
        end
    end

    // last flag only rides on a strobe
    a_last_with_v : assert property (
        @(posedge clk) disable iff (rst)
        in_last |-> in_v
    );

endmodule

`default_nettype wire

// ==== source/mac_core.sv ====
`default_nettype none

module mac_core
    import accel_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // shared pair bus, this core's select bit
    input  operand_t pair_a,
    input  operand_t pair_b,
    input  logic     take,

    // clear from the stream sequencer
    input  logic     acc_clr,

    output acc_t     acc
);

    // stage one
    product_t prod;
    logic     prod_v;

    // ==================================================
    // stage one, multiply
    // ==================================================

    always_ff @(posedge clk) begin
        if (acc_clr) begin
            prod <= '0;
        end
        else if (take) begin
            prod <= product_t'(pair_a) * product_t'(pair_b);
        end
    end

    // marks a product waiting for stage two
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_v <= 1'b0;
        end
        else if (acc_clr) begin
            prod_v <= 1'b0;
        end
        else begin
            prod_v <= take;
        end
    end

    // ==================================================
    // stage two, accumulate
    // ==================================================

    // wraps silently at ACC_W bits
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end
        else if (acc_clr) begin
            acc <= '0;
        end
        else if (prod_v) begin
            acc <= acc + acc_t'(prod);
        end
    end

endmodule

`default_nettype wire

// ==== source/stream_ctrl.sv ====
`default_nettype none

module stream_ctrl
    import accel_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // from dispatch and the core array
    input  logic     job_last,
    input  acc_bus_t acc_bus,

    // result stream
    input  logic     dst_ready,
    output logic     dst_valid,
    output acc_t     dst_data,
    output logic     dst_last,

    // shared clear to all cores
    output logic     acc_clr
);

    stream_state_t state;
    stream_state_t state_nxt;

    // second settle cycle
    logic      settle_done;

    // output core index
    core_idx_t idx;
    logic      idx_last;
    logic      agu_start;
    logic      agu_en;

    // ==================================================
    // sequencer FSM
    // ==================================================

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (job_last) begin
                    state_nxt = st_settle;
                end
            end
            // core pipelines are two deep
            st_settle: begin
                if (settle_done) begin
                    state_nxt = st_stream;
                end
            end
            st_stream: begin
                if (dst_ready && idx_last) begin
                    state_nxt = st_drain;
                end
            end
            // final word waits in the output register
            st_drain: begin
                if (dst_ready) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end
        else begin
            state <= state_nxt;
        end
    end

    // toggles once per settle cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            settle_done <= 1'b0;
        end
        else if (state == st_settle) begin
            settle_done <= ~settle_done;
        end
        else begin
            settle_done <= 1'b0;
        end
    end

    // ==================================================
    // core index
    // ==================================================

    // rewound to core 0 during settle, steps per loaded word
    assign agu_start = (state == st_settle);
    assign agu_en    = agu_start | ((state == st_stream) & dst_ready);

    agu i_agu (
        .clk   (clk),
        .rst   (rst),
        .start (agu_start),
        .en    (agu_en),
        .ini   (core_idx_t'(0)),
        .fin   (core_idx_t'(CORE_NUM - 1)),
        .data  (idx),
        .last  (idx_last)
    );

    // ==================================================
    // output register, advances only with dst_ready
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end
        else if (dst_ready) begin
            dst_valid <= (state == st_stream);
            dst_last  <= (state == st_stream) & idx_last;
        end
    end

    // result slice of the indexed core
    always_ff @(posedge clk) begin
        if (dst_ready && (state == st_stream)) begin
            dst_data <= acc_bus[idx*ACC_W +: ACC_W];
        end
    end

    // final word leaving, cores start the next job from zero
    assign acc_clr = (state == st_drain) & dst_ready;

    // next job only after dst_last is accepted
    a_no_overlap : assert property (
        @(posedge clk) disable iff (rst)
        job_last |-> (state == st_idle)
    );

    // stalled word stays put until taken
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (rst)
        (dst_valid && !dst_ready) |=> dst_valid && $stable(dst_data) && $stable(dst_last)
    );

endmodule

`default_nettype wire
